// File: testbench/decode_testdata.txt
# W reg value                (register write through the writeback port, hex)
# I instr pc wsel reg_wr wr_link mem_rd mem_wr alu_src alu_op pc_src halt
#   ext_out rdat1 rdat2 j_offset   (all hex, expected decode results)
W 01 12345678
W 02 0000abcd
W 03 fffffff0
W 04 80000001
W 05 00000005
W 00 deadbeef
W 1f 0badf00d
W 08 00001000
W 09 cafebabe
I 00223021 00400000 06 1 0 0 0 0 0 0 0 00003021 12345678 0000abcd 0223021
I 00643823 00400004 07 1 0 0 0 0 1 0 0 00003823 fffffff0 80000001 0643823
I 00235024 00400008 0a 1 0 0 0 0 2 0 0 00005024 12345678 fffffff0 0235024
I 00455825 0040000c 0b 1 0 0 0 0 3 0 0 00005825 0000abcd 00000005 0455825
I 0085602a 00400010 0c 1 0 0 0 0 4 0 0 0000602a 80000001 00000005 085602a
I 00056900 00400014 0d 1 0 0 0 0 5 0 0 00006900 00000000 00000005 0056900
I 03e00008 00400018 00 0 0 0 0 0 0 4 0 00000008 0badf00d 00000000 3e00008
I 242e1234 0040001c 0e 1 0 0 0 1 0 0 0 00001234 12345678 00000000 02e1234
I 244ffff0 00400020 0f 1 0 0 0 1 0 0 0 fffffff0 0000abcd 00000000 04ffff0
I 28708000 00400024 10 1 0 0 0 1 4 0 0 ffff8000 fffffff0 00000000 0708000
I 3091ff00 00400028 11 1 0 0 0 1 2 0 0 0000ff00 80000001 00000000 091ff00
I 34b28421 0040002c 12 1 0 0 0 1 3 0 0 00008421 00000005 00000000 0b28421
I 3c13abcd 00400030 13 1 0 0 0 1 6 0 0 abcd0000 00000000 00000000 013abcd
I 8d14fffc 00400034 14 1 0 1 0 1 0 0 0 fffffffc 00001000 00000000 114fffc
I ad090010 00400038 09 0 0 0 1 1 0 0 0 00000010 00001000 cafebabe 1090010
I 1022fffe 0040003c 02 0 0 0 0 0 1 1 0 fffffffe 12345678 0000abcd 022fffe
I 14640004 00400040 04 0 0 0 0 0 1 2 0 00000004 fffffff0 80000001 0640004
I 08100040 00400044 10 0 0 0 0 0 0 3 0 00000040 00000000 00000000 0100040
I 0fffff00 00400048 1f 1 1 0 0 0 0 3 0 0000ff00 0badf00d 0badf00d 3ffff00
I fc000000 0040004c 00 0 0 0 0 0 0 0 1 00000000 00000000 00000000 0000000
I 0009a825 00400050 15 1 0 0 0 0 3 0 0 0000a825 00000000 cafebabe 009a825
W 05 00000077
I 00a0b021 00400054 16 1 0 0 0 0 0 0 0 0000b021 00000077 00000000 0a0b021

// File: sim.f
verilog/cpu_types_pkg.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/instr_latch.sv
verilog/decode_stage.sv
verilog/decode_top.sv
testbench/tb_clock.sv
testbench/decode_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the decode testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f sim.f \
  --top-module decode_tb \
  -o decode_sim

./obj_dir/decode_sim 2>&1 | tee sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: testbench/decode_tb.sv
// Decode testbench driving file-based req/ack and valid/ready traffic with decode result checks
`timescale 1ns/10ps

module decode_tb import cpu_types_pkg::*; ();

  localparam int MAX_RECS   = 64;
  localparam int SWEEP_RECS = 16;
  localparam int NUM_FIELDS = 15;

  logic    CLK;
  logic    rst;
  logic    instr_req;
  logic    instr_ack;
  word_t   instr;
  word_t   pc;
  logic    wb_en;
  regsel_t wb_sel;
  word_t   wb_data;
  logic    dec_valid;
  logic    dec_ready;
  logic    halt;
  logic    reg_wr;
  logic    mem_to_reg;
  logic    wr_link;
  logic    mem_rd;
  logic    mem_wr;
  logic    alu_src;
  pcsrc_t  pc_src;
  aluop_t  alu_op;
  regsel_t wsel;
  regsel_t rs;
  regsel_t rt;
  word_t   ext_out;
  word_t   rdat1;
  word_t   rdat2;
  word_t   dec_pc;
  joff_t   j_offset;

  // Record kinds W for register write, I for instruction, Z for reset read sweep
  // Fields of an I record in file order
  //   instr pc wsel reg_wr wr_link mem_rd mem_wr alu_src alu_op pc_src halt
  //   ext_out rdat1 rdat2 j_offset
  logic [7:0]  rec_kind [MAX_RECS];
  logic [31:0] rec_val  [MAX_RECS][NUM_FIELDS];
  int          num_recs;
  bit          loaded;
  bit          failed;
  bit          early_req;
  integer      seed;

  tb_clock clk_gen (.CLK(CLK));

  decode_top UUT (
    .CLK        (CLK),
    .rst        (rst),
    .instr_req  (instr_req),
    .instr_ack  (instr_ack),
    .instr      (instr),
    .pc         (pc),
    .wb_en      (wb_en),
    .wb_sel     (wb_sel),
    .wb_data    (wb_data),
    .dec_valid  (dec_valid),
    .dec_ready  (dec_ready),
    .halt       (halt),
    .reg_wr     (reg_wr),
    .mem_to_reg (mem_to_reg),
    .wr_link    (wr_link),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .alu_src    (alu_src),
    .pc_src     (pc_src),
    .alu_op     (alu_op),
    .wsel       (wsel),
    .rs         (rs),
    .rt         (rt),
    .ext_out    (ext_out),
    .rdat1      (rdat1),
    .rdat2      (rdat2),
    .dec_pc     (dec_pc),
    .j_offset   (j_offset)
  );

  task automatic stop_run(string what);
    failed = 1'b1;
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      stop_run($sformatf("FAILED %s expected 0x%h actual 0x%h", name, expected, actual));
    end
  endtask

  task automatic check_cond(bit ok, string what);
    assert (ok) else begin
      stop_run(what);
    end
  endtask

  task automatic load_records();
    int          fd;
    int          code;
    int          c;
    logic [7:0]  tag;
    logic [31:0] vals [NUM_FIELDS];
    num_recs = 0;
    // Reset sweep of ADDU records that read every register pair as zero
    for (int k = 0; k < SWEEP_RECS; k++) begin
      rec_kind[k] = "Z";
      rec_val[k][0] = {OP_RTYPE, regsel_t'(2 * k), regsel_t'(2 * k + 1), 5'd0, 5'd0, FN_ADDU};
      rec_val[k][1] = 32'h0040_1000 + 32'(4 * k);
      rec_val[k][12] = 32'h0;
      rec_val[k][13] = 32'h0;
    end
    num_recs = SWEEP_RECS;
    fd = $fopen("testbench/decode_testdata.txt", "r");
    check_cond(fd != 0, "Could not open the testdata file");
    while (1) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        break;
      end
      if (tag == "#") begin
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
      end else begin
        if (tag == "W") begin
          code = $fscanf(fd, "%h %h", vals[0], vals[1]);
          check_cond(code == 2, "Malformed register write record in the testdata file");
        end else if (tag == "I") begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         vals[0], vals[1], vals[2], vals[3], vals[4], vals[5], vals[6],
                         vals[7], vals[8], vals[9], vals[10], vals[11], vals[12],
                         vals[13], vals[14]);
          check_cond(code == NUM_FIELDS, "Malformed instruction record in the testdata file");
        end else begin
          check_cond(1'b0, "Unknown record type in the testdata file");
        end
        check_cond(num_recs < MAX_RECS, "Too many records in the testdata file");
        rec_kind[num_recs] = tag;
        for (int f = 0; f < NUM_FIELDS; f++) begin
          rec_val[num_recs][f] = vals[f];
        end
        num_recs++;
      end
    end
    $fclose(fd);
  endtask

  task automatic write_register(int n);
    @(posedge CLK);
    wb_en   <= 1'b1;
    wb_sel  <= rec_val[n][0][4:0];
    wb_data <= rec_val[n][1];
    @(posedge CLK);
    wb_en <= 1'b0;
    @(negedge CLK);
  endtask

  task automatic check_bundle(int n);
    check_value("dec_valid", 32'h1, 32'(dec_valid));
    check_value("dec_pc", rec_val[n][1], dec_pc);
    // Source register fields of the MIPS encoding
    check_value("rs", 32'(rec_val[n][0][25:21]), 32'(rs));
    check_value("rt", 32'(rec_val[n][0][20:16]), 32'(rt));
    check_value("rdat1", rec_val[n][12], rdat1);
    check_value("rdat2", rec_val[n][13], rdat2);
    if (rec_kind[n] == "I") begin
      check_value("wsel", rec_val[n][2], 32'(wsel));
      check_value("reg_wr", rec_val[n][3], 32'(reg_wr));
      check_value("wr_link", rec_val[n][4], 32'(wr_link));
      check_value("mem_rd", rec_val[n][5], 32'(mem_rd));
      // Only loads write back memory data
      check_value("mem_to_reg", rec_val[n][5], 32'(mem_to_reg));
      check_value("mem_wr", rec_val[n][6], 32'(mem_wr));
      check_value("alu_src", rec_val[n][7], 32'(alu_src));
      check_value("alu_op", rec_val[n][8], 32'(alu_op));
      check_value("pc_src", rec_val[n][9], 32'(pc_src));
      check_value("halt", rec_val[n][10], 32'(halt));
      check_value("ext_out", rec_val[n][11], ext_out);
      check_value("j_offset", rec_val[n][14], 32'(j_offset));
    end
  endtask

  task automatic run_instruction(int n);
    bit prev_valid;
    int hold;
    prev_valid = dec_valid;
    if (!early_req) begin
      @(posedge CLK);
      instr     <= rec_val[n][0];
      pc        <= rec_val[n][1];
      instr_req <= 1'b1;
    end
    early_req = 1'b0;
    @(negedge CLK);
    while (!instr_ack) begin
      prev_valid = dec_valid;
      @(negedge CLK);
    end
    check_cond(!prev_valid, "instr_ack rose while the latch still held an instruction");
    check_cond(dec_valid, "dec_valid did not rise together with instr_ack");
    // Ack has to stay up while the request is held one more cycle
    @(negedge CLK);
    check_cond(instr_ack, "instr_ack fell while instr_req was still high");
    @(posedge CLK);
    instr_req <= 1'b0;
    @(negedge CLK);
    while (instr_ack) begin
      @(negedge CLK);
    end
    check_bundle(n);
    hold = $unsigned($random(seed)) % 4;
    for (int h = 0; h < hold; h++) begin
      @(posedge CLK);
      if (h == 0 && n + 1 < num_recs && rec_kind[n + 1] != "W") begin
        // Next request waits behind the held bundle
        instr     <= rec_val[n + 1][0];
        pc        <= rec_val[n + 1][1];
        instr_req <= 1'b1;
        early_req = 1'b1;
      end
      @(negedge CLK);
      check_cond(!instr_ack, "instr_ack rose while dec_valid was still high");
      check_bundle(n);
    end
    @(posedge CLK);
    dec_ready <= 1'b1;
    @(negedge CLK);
    check_bundle(n);
    @(posedge CLK);
    dec_ready <= 1'b0;
    @(negedge CLK);
    check_value("dec_valid", 32'h0, 32'(dec_valid));
    check_value("instr_ack", 32'h0, 32'(instr_ack));
  endtask

  initial begin
    rst       = 1'b1;
    instr_req = 1'b0;
    instr     = '0;
    pc        = '0;
    wb_en     = 1'b0;
    wb_sel    = '0;
    wb_data   = '0;
    dec_ready = 1'b0;
    seed      = 37;
    failed    = 1'b0;
    early_req = 1'b0;
    loaded    = 1'b0;
    load_records();
    loaded = 1'b1;
    repeat (5) @(posedge CLK);
    rst <= 1'b0;
    @(negedge CLK);
    check_value("instr_ack", 32'h0, 32'(instr_ack));
    check_value("dec_valid", 32'h0, 32'(dec_valid));
    for (int n = 0; n < num_recs; n++) begin
      if (rec_kind[n] == "W") begin
        write_register(n);
      end else begin
        run_instruction(n);
      end
    end
    if (!failed) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog scaled by the number of records
  initial begin
    int limit;
    wait (loaded);
    limit = num_recs * 20 + 50;
    repeat (limit) @(posedge CLK);
    stop_run($sformatf("Timeout: the run did not finish within %0d clock cycles", limit));
  end

endmodule

// File: testbench/tb_clock.sv
// Testbench clock generator with a 20 ns period
`timescale 1ns/10ps

module tb_clock (
  output logic CLK
);

  initial begin
    CLK = 1'b0;
    forever begin
      #10 CLK = ~CLK;
    end
  end

endmodule

// File: verilog/decode_top.sv
// Decode top: fetch/decode latch feeding the decode stage
`timescale 1ns/10ps

module decode_top import cpu_types_pkg::*; (
  input  logic    CLK,
  input  logic    rst,
  input  logic    instr_req,
  output logic    instr_ack,
  input  word_t   instr,
  input  word_t   pc,
  input  logic    wb_en,
  input  regsel_t wb_sel,
  input  word_t   wb_data,
  output logic    dec_valid,
  input  logic    dec_ready,
  output logic    halt,
  output logic    reg_wr,
  output logic    mem_to_reg,
  output logic    wr_link,
  output logic    mem_rd,
  output logic    mem_wr,
  output logic    alu_src,
  output pcsrc_t  pc_src,
  output aluop_t  alu_op,
  output regsel_t wsel,
  output regsel_t rs,
  output regsel_t rt,
  output word_t   ext_out,
  output word_t   rdat1,
  output word_t   rdat2,
  output word_t   dec_pc,
  output joff_t   j_offset
);

  word_t lat_instr;
  word_t lat_pc;

  // Valid is the latch occupancy
  instr_latch latch (
    .CLK       (CLK),
    .rst       (rst),
    .instr_req (instr_req),
    .instr_ack (instr_ack),
    .instr     (instr),
    .pc        (pc),
    .dec_ready (dec_ready),
    .full      (dec_valid),
    .lat_instr (lat_instr),
    .lat_pc    (lat_pc)
  );

  decode_stage decode (
    .CLK        (CLK),
    .rst        (rst),
    .lat_instr  (lat_instr),
    .lat_pc     (lat_pc),
    .wb_en      (wb_en),
    .wb_sel     (wb_sel),
    .wb_data    (wb_data),
    .halt       (halt),
    .reg_wr     (reg_wr),
    .mem_to_reg (mem_to_reg),
    .wr_link    (wr_link),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .alu_src    (alu_src),
    .pc_src     (pc_src),
    .alu_op     (alu_op),
    .wsel       (wsel),
    .rs         (rs),
    .rt         (rt),
    .ext_out    (ext_out),
    .rdat1      (rdat1),
    .rdat2      (rdat2),
    .dec_pc     (dec_pc),
    .j_offset   (j_offset)
  );

endmodule

// File: verilog/decode_stage.sv
// Decode stage: field split, immediate extend, dest select, controls and reg reads
`timescale 1ns/10ps

module decode_stage import cpu_types_pkg::*; (
  input  logic    CLK,
  input  logic    rst,
  input  word_t   lat_instr,
  input  word_t   lat_pc,
  input  logic    wb_en,
  input  regsel_t wb_sel,
  input  word_t   wb_data,
  output logic    halt,
  output logic    reg_wr,
  output logic    mem_to_reg,
  output logic    wr_link,
  output logic    mem_rd,
  output logic    mem_wr,
  output logic    alu_src,
  output pcsrc_t  pc_src,
  output aluop_t  alu_op,
  output regsel_t wsel,
  output regsel_t rs,
  output regsel_t rt,
  output word_t   ext_out,
  output word_t   rdat1,
  output word_t   rdat2,
  output word_t   dec_pc,
  output joff_t   j_offset
);

  opcode_t opcode;
  funct_t  funct;
  regsel_t rd;
  imm_t    imm;
  logic    reg_dst;
  logic    ext_op;
  logic    shift_up;

  // Instruction fields
  assign opcode   = lat_instr[31:26];
  assign rs       = lat_instr[25:21];
  assign rt       = lat_instr[20:16];
  assign rd       = lat_instr[15:11];
  assign funct    = lat_instr[5:0];
  assign imm      = lat_instr[15:0];
  assign j_offset = lat_instr[25:0];
  assign dec_pc   = lat_pc;

  control_unit ctrl (
    .opcode     (opcode),
    .funct      (funct),
    .reg_wr     (reg_wr),
    .reg_dst    (reg_dst),
    .wr_link    (wr_link),
    .mem_to_reg (mem_to_reg),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .alu_src    (alu_src),
    .ext_op     (ext_op),
    .shift_up   (shift_up),
    .halt       (halt),
    .alu_op     (alu_op),
    .pc_src     (pc_src)
  );

  register_file regs (
    .CLK   (CLK),
    .rst   (rst),
    .rsel1 (rs),
    .rsel2 (rt),
    .rdat1 (rdat1),
    .rdat2 (rdat2),
    .wen   (wb_en),
    .wsel  (wb_sel),
    .wdat  (wb_data)
  );

  // Sign extend, upper shift, else zero extend
  always_comb begin
    ext_out = {16'h0000, imm};
    if (ext_op && imm[15]) begin
      ext_out = {16'hffff, imm};
    end else if (shift_up) begin
      ext_out = {imm, 16'h0000};
    end
  end

  // Link write goes to r31
  assign wsel = wr_link ? LINK_REG : (reg_dst ? rd : rt);

endmodule

// File: verilog/instr_latch.sv
// Fetch/decode latch: four-phase req/ack receiver holding one instruction and PC
`timescale 1ns/10ps

module instr_latch import cpu_types_pkg::*; (
  input  logic  CLK,
  input  logic  rst,
  input  logic  instr_req,
  output logic  instr_ack,
  input  word_t instr,
  input  word_t pc,
  input  logic  dec_ready,
  output logic  full,
  output word_t lat_instr,
  output word_t lat_pc
);

  logic capture;

  // Accept a new request only when empty and the last ack has dropped
  assign capture = instr_req && !instr_ack && !full;

  always_ff @(posedge CLK) begin
    if (rst) begin
      instr_ack <= 1'b0;
    end else if (capture) begin
      instr_ack <= 1'b1;
    end else if (!instr_req) begin
      // Return to zero phase
      instr_ack <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      full <= 1'b0;
    end else if (capture) begin
      full <= 1'b1;
    end else if (dec_ready) begin
      // Downstream took the bundle
      full <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (capture) begin
      lat_instr <= instr;
      lat_pc    <= pc;
    end
  end

endmodule

// File: verilog/register_file.sv
// Register file: 32 x 32-bit, two combinational reads, one synchronous write
`timescale 1ns/10ps

module register_file import cpu_types_pkg::*; (
  input  logic    CLK,
  input  logic    rst,
  input  regsel_t rsel1,
  input  regsel_t rsel2,
  output word_t   rdat1,
  output word_t   rdat2,
  input  logic    wen,
  input  regsel_t wsel,
  input  word_t   wdat
);

  word_t regs [32];

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // Register 0 reads zero, no write bypass
  assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

// File: verilog/control_unit.sv
// Control unit: combinational decode of opcode and funct into datapath controls
`timescale 1ns/10ps

module control_unit import cpu_types_pkg::*; (
  input  opcode_t opcode,
  input  funct_t  funct,
  output logic    reg_wr,
  output logic    reg_dst,
  output logic    wr_link,
  output logic    mem_to_reg,
  output logic    mem_rd,
  output logic    mem_wr,
  output logic    alu_src,
  output logic    ext_op,
  output logic    shift_up,
  output logic    halt,
  output aluop_t  alu_op,
  output pcsrc_t  pc_src
);

  always_comb begin
    // Inactive unless an instruction below says otherwise
    reg_wr     = 1'b0;
    reg_dst    = 1'b0;
    wr_link    = 1'b0;
    mem_to_reg = 1'b0;
    mem_rd     = 1'b0;
    mem_wr     = 1'b0;
    alu_src    = 1'b0;
    ext_op     = 1'b0;
    shift_up   = 1'b0;
    halt       = 1'b0;
    alu_op     = ALU_ADD;
    pc_src     = PC_NEXT;

    case (opcode)
      OP_RTYPE: begin
        reg_dst = 1'b1;
        case (funct)
          FN_SLL:  begin reg_wr = 1'b1; alu_op = ALU_SLL; end
          FN_ADDU: begin reg_wr = 1'b1; alu_op = ALU_ADD; end
          FN_SUBU: begin reg_wr = 1'b1; alu_op = ALU_SUB; end
          FN_AND:  begin reg_wr = 1'b1; alu_op = ALU_AND; end
          FN_OR:   begin reg_wr = 1'b1; alu_op = ALU_OR;  end
          FN_SLT:  begin reg_wr = 1'b1; alu_op = ALU_SLT; end
          FN_JR:   pc_src = PC_JR;
          default: reg_dst = 1'b0;
        endcase
      end
      OP_J:     pc_src = PC_JUMP;
      OP_JAL: begin
        pc_src  = PC_JUMP;
        reg_wr  = 1'b1;
        wr_link = 1'b1;
      end
      // Branch compare is a subtract, offset sign-extended
      OP_BEQ:   begin pc_src = PC_BEQ; alu_op = ALU_SUB; ext_op = 1'b1; end
      OP_BNE:   begin pc_src = PC_BNE; alu_op = ALU_SUB; ext_op = 1'b1; end
      OP_ADDIU: begin reg_wr = 1'b1; alu_src = 1'b1; ext_op = 1'b1; end
      OP_SLTI: begin
        reg_wr  = 1'b1;
        alu_src = 1'b1;
        ext_op  = 1'b1;
        alu_op  = ALU_SLT;
      end
      OP_ANDI:  begin reg_wr = 1'b1; alu_src = 1'b1; alu_op = ALU_AND; end
      OP_ORI:   begin reg_wr = 1'b1; alu_src = 1'b1; alu_op = ALU_OR; end
      OP_LUI: begin
        reg_wr   = 1'b1;
        alu_src  = 1'b1;
        shift_up = 1'b1;
        alu_op   = ALU_LUI;
      end
      OP_LW: begin
        reg_wr     = 1'b1;
        mem_to_reg = 1'b1;
        mem_rd     = 1'b1;
        alu_src    = 1'b1;
        ext_op     = 1'b1;
      end
      OP_SW:    begin mem_wr = 1'b1; alu_src = 1'b1; ext_op = 1'b1; end
      OP_HALT:  halt = 1'b1;
      default:  ;
    endcase
  end

endmodule

// File: verilog/cpu_types_pkg.sv
// CPU types package: field widths, opcode and funct codes, decode enums
package cpu_types_pkg;

  // Widths that carry a meaning
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regsel_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;
  typedef logic [25:0] joff_t;

  // Major opcodes
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDIU = 6'h09;
  localparam opcode_t OP_SLTI  = 6'h0A;
  localparam opcode_t OP_ANDI  = 6'h0C;
  localparam opcode_t OP_ORI   = 6'h0D;
  localparam opcode_t OP_LUI   = 6'h0F;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2B;
  localparam opcode_t OP_HALT  = 6'h3F;

  // R-type function codes
  localparam funct_t FN_SLL  = 6'h00;
  localparam funct_t FN_JR   = 6'h08;
  localparam funct_t FN_ADDU = 6'h21;
  localparam funct_t FN_SUBU = 6'h23;
  localparam funct_t FN_AND  = 6'h24;
  localparam funct_t FN_OR   = 6'h25;
  localparam funct_t FN_SLT  = 6'h2A;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4,
    ALU_SLL = 3'd5,
    ALU_LUI = 3'd6
  } aluop_t;

  typedef enum logic [2:0] {
    PC_NEXT = 3'd0,
    PC_BEQ  = 3'd1,
    PC_BNE  = 3'd2,
    PC_JUMP = 3'd3,
    PC_JR   = 3'd4
  } pcsrc_t;

  // Return address register for JAL
  localparam regsel_t LINK_REG = 5'd31;

endpackage
